// ==== source/execute_pkg.sv ====
// Shared widths and micro-op field encodings; imported by the execute stage RTL and its testbench
package execute_pkg;

    localparam int xlen       = 32;             // Data path width
    localparam int reg_addr_w = 5;              // Register file index
    localparam int shamt_w    = $clog2(xlen);   // Shift amount taken from operand 2
    localparam int cnt_w      = $clog2(xlen) + 1; // Bit counts reach 32
    localparam int mul_w      = xlen + 1;       // Operand with room for the sign choice
    localparam int prod_w     = 2 * mul_w;      // Full signed product

    // Which unit produces the result of the micro-op
    typedef enum logic [1:0] {
        unit_none     = 2'd0,
        unit_alu      = 2'd1,
        unit_bitmanip = 2'd2,
        unit_mul      = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,                        // Also branch and jump targets
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        bit_rvrs  = 3'd0,                       // Byte reverse
        bit_cntz  = 3'd1,                       // Trailing zero count
        bit_cntp  = 3'd2,                       // Population count
        bit_pkg   = 3'd3,                       // Pack low halves
        bit_sladd = 3'd4,                       // Shift left by one and add
        bit_hmdst = 3'd5                        // Hamming distance
    } bit_op_e;

    typedef enum logic [1:0] {
        mul_mul    = 2'd0,
        mul_mulh   = 2'd1,
        mul_mulhsu = 2'd2,
        mul_mulhu  = 2'd3
    } mul_op_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_eq   = 4'd1,
        br_ne   = 4'd2,
        br_lt   = 4'd3,
        br_ge   = 4'd4,
        br_ltu  = 4'd5,
        br_geu  = 4'd6,
        br_jal  = 4'd7,
        br_jalr = 4'd8
    } branch_op_e;

endpackage

// ==== source/arith_logic_unit.sv ====
// Combinational integer ALU of the execute stage; its adder output also serves as the branch target
`timescale 1ns/1ps

module arith_logic_unit (
    input  execute_pkg::alu_op_e          op_i,
    input  logic [execute_pkg::xlen-1:0]  value1_i,
    input  logic [execute_pkg::xlen-1:0]  value2_i,
    output logic [execute_pkg::xlen-1:0]  result_o
);

    import execute_pkg::*;

    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;
    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign sum   = value1_i + value2_i;         // Single adder for add and targets
    assign diff  = value1_i - value2_i;
    assign shamt = value2_i[shamt_w-1:0];       // Only low bits select the shift

    assign lt_signed   = $signed(value1_i) < $signed(value2_i);
    assign lt_unsigned = value1_i < value2_i;

    always_comb begin
        case (op_i)
            alu_add: begin
                result_o = sum;
            end
            alu_sub: begin
                result_o = diff;
            end
            alu_and: begin
                result_o = value1_i & value2_i;
            end
            alu_or: begin
                result_o = value1_i | value2_i;
            end
            alu_xor: begin
                result_o = value1_i ^ value2_i;
            end
            alu_sll: begin
                result_o = value1_i << shamt;
            end
            alu_srl: begin
                result_o = value1_i >> shamt;
            end
            alu_sra: begin
                result_o = $signed(value1_i) >>> shamt; // Sign bit fills from the top
            end
            alu_slt: begin
                result_o = {{(xlen - 1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result_o = {{(xlen - 1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_o = sum;                 // Unused codes behave as add
            end
        endcase
    end

endmodule

// ==== source/bit_manip_unit.sv ====
// Combinational bit-manipulation unit of the execute stage for the extension operations
`timescale 1ns/1ps

module bit_manip_unit (
    input  execute_pkg::bit_op_e          op_i,
    input  logic [execute_pkg::xlen-1:0]  value1_i,
    input  logic [execute_pkg::xlen-1:0]  value2_i,
    output logic [execute_pkg::xlen-1:0]  result_o
);

    import execute_pkg::*;

    logic [xlen-1:0]  byte_rev;
    logic [xlen-1:0]  pop_src;
    logic [cnt_w-1:0] pop_count;
    logic [cnt_w-1:0] tz_count;
    logic [xlen-1:0]  packed_val;
    logic [xlen-1:0]  shadd_val;

    assign byte_rev = {value1_i[7:0], value1_i[15:8], value1_i[23:16], value1_i[31:24]};

    // One counter serves both cntp and hmdst
    assign pop_src = (op_i == bit_hmdst) ? (value1_i ^ value2_i) : value1_i;

    always_comb begin
        pop_count = '0;
        for (int i = 0; i < xlen; i++) begin
            pop_count = pop_count + cnt_w'(pop_src[i]);
        end
    end

    // Scan from the top so the lowest set bit wins
    always_comb begin
        tz_count = cnt_w'(xlen);                // All zero input gives 32
        for (int i = xlen - 1; i >= 0; i--) begin
            if (value1_i[i]) begin
                tz_count = cnt_w'(i);
            end
        end
    end

    assign packed_val = {value2_i[xlen/2-1:0], value1_i[xlen/2-1:0]}; // Value1 in low half
    assign shadd_val  = (value1_i << 1) + value2_i;

    always_comb begin
        case (op_i)
            bit_rvrs: begin
                result_o = byte_rev;
            end
            bit_cntz: begin
                result_o = {{(xlen - cnt_w){1'b0}}, tz_count};
            end
            bit_cntp: begin
                result_o = {{(xlen - cnt_w){1'b0}}, pop_count};
            end
            bit_pkg: begin
                result_o = packed_val;
            end
            bit_sladd: begin
                result_o = shadd_val;
            end
            bit_hmdst: begin
                result_o = {{(xlen - cnt_w){1'b0}}, pop_count}; // XOR already applied
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== source/multiplier_unit.sv ====
// Two-stage pipelined signed multiplier for mul, mulh, mulhsu and mulhu; result two edges after start
`timescale 1ns/1ps

module multiplier_unit (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  execute_pkg::mul_op_e          op_i,
    input  logic [execute_pkg::xlen-1:0]  value1_i,
    input  logic [execute_pkg::xlen-1:0]  value2_i,
    output logic                          done_o,
    output logic [execute_pkg::xlen-1:0]  result_o
);

    import execute_pkg::*;

    logic               op1_signed;
    logic               op2_signed;
    logic [mul_w-1:0]   op1_ext;
    logic [mul_w-1:0]   op2_ext;

    logic signed [mul_w-1:0]  op1_q;            // Stage 1 operands
    logic signed [mul_w-1:0]  op2_q;
    logic                     high_q;
    logic                     valid1_q;

    logic signed [prod_w-1:0] product;

    // Signedness per operation
    assign op1_signed = (op_i == mul_mulh) || (op_i == mul_mulhsu);
    assign op2_signed = (op_i == mul_mulh);

    assign op1_ext = {op1_signed & value1_i[xlen-1], value1_i};
    assign op2_ext = {op2_signed & value2_i[xlen-1], value2_i};

    // Valid pipeline
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid1_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            valid1_q <= start_i;
            done_o   <= valid1_q;
        end
    end

    // Stage 1 captures extended operands
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            op1_q  <= $signed(op1_ext);
            op2_q  <= $signed(op2_ext);
            high_q <= (op_i != mul_mul);        // Every other op wants the upper word
        end
    end

    assign product = op1_q * op2_q;             // 33x33 fits 66 bits with no overflow

    // Stage 2 picks the wanted word
    always_ff @(posedge clk_i) begin
        if (valid1_q) begin
            if (high_q) begin
                result_o <= product[2*xlen-1:xlen];
            end else begin
                result_o <= product[xlen-1:0];
            end
        end
    end

endmodule

// ==== source/execute_stage.sv ====
// Execute stage top; runs ALU, bit-manip and multiply micro-ops, resolves branches, drives writeback
`timescale 1ns/1ps

module execute_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,

    // Decoded micro-op from register read
    input  execute_pkg::unit_e                  unit_i,
    input  execute_pkg::alu_op_e                alu_op_i,
    input  execute_pkg::bit_op_e                bit_op_i,
    input  execute_pkg::mul_op_e                mul_op_i,
    input  execute_pkg::branch_op_e             branch_op_i,
    input  logic [execute_pkg::reg_addr_w-1:0]  rd_addr_i,
    input  logic                                rd_write_i,
    input  logic [execute_pkg::xlen-1:1]        pc_plus4_i,     // Halfword address of PC+4
    input  logic [execute_pkg::xlen-1:0]        value1_i,       // Forwarded and imm selected
    input  logic [execute_pkg::xlen-1:0]        value2_i,
    input  logic                                cmp_lt_i,
    input  logic                                cmp_ltu_i,
    input  logic                                cmp_eq_i,

    // Branch resolution in the issue cycle
    output logic [execute_pkg::xlen-1:1]        branch_target_o,
    output logic                                branch_taken_o,

    // Forwarding back to decode
    output logic [execute_pkg::xlen-1:0]        forward_value_o,
    output logic                                forward_valid_o,

    // Single-cycle writeback port
    output logic                                wb_write_en_o,
    output logic [execute_pkg::reg_addr_w-1:0]  wb_rd_addr_o,
    output logic [execute_pkg::xlen-1:0]        wb_rd_value_o,

    // Multiplier writeback port
    output logic                                mul_write_en_o,
    output logic [execute_pkg::reg_addr_w-1:0]  mul_rd_addr_o,
    output logic [execute_pkg::xlen-1:0]        mul_value_o
);

    import execute_pkg::*;

    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       bit_result;
    logic [xlen-1:0]       unit_result;
    logic [xlen-1:0]       link_value;
    logic [xlen-1:0]       rd_value_next;
    logic                  is_jump;
    logic                  single_cycle;
    logic                  mul_start;
    logic                  mul_done;

    logic [reg_addr_w-1:0] mul_rd_q1;           // Metadata beside multiplier stage 1
    logic                  mul_wr_q1;
    logic                  mul_wr_q2;

    arith_logic_unit alu_i (
        .op_i     (alu_op_i),
        .value1_i (value1_i),
        .value2_i (value2_i),
        .result_o (alu_result)
    );

    bit_manip_unit bit_manip_i (
        .op_i     (bit_op_i),
        .value1_i (value1_i),
        .value2_i (value2_i),
        .result_o (bit_result)
    );

    assign mul_start = (unit_i == unit_mul);

    multiplier_unit multiplier_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .op_i     (mul_op_i),
        .value1_i (value1_i),
        .value2_i (value2_i),
        .done_o   (mul_done),
        .result_o (mul_value_o)
    );

    // Branch condition decoder
    always_comb begin
        case (branch_op_i)
            br_eq:   branch_taken_o = cmp_eq_i;
            br_ne:   branch_taken_o = ~cmp_eq_i;
            br_lt:   branch_taken_o = cmp_lt_i;
            br_ge:   branch_taken_o = ~cmp_lt_i;
            br_ltu:  branch_taken_o = cmp_ltu_i;
            br_geu:  branch_taken_o = ~cmp_ltu_i;
            br_jal:  branch_taken_o = 1'b1;
            br_jalr: branch_taken_o = 1'b1;
            default: branch_taken_o = 1'b0;     // None and unused codes never redirect
        endcase
    end

    assign branch_target_o = alu_result[xlen-1:1]; // PC+imm or rs1+imm from the ALU adder

    assign is_jump    = (branch_op_i == br_jal) || (branch_op_i == br_jalr);
    assign link_value = {pc_plus4_i, 1'b0};     // Back to a byte address

    // Unit selector
    assign unit_result   = (unit_i == unit_bitmanip) ? bit_result : alu_result;
    assign rd_value_next = is_jump ? link_value : unit_result;

    // Result known this cycle for ALU, bit-manip and jumps only
    assign single_cycle = ((unit_i == unit_alu) || (unit_i == unit_bitmanip) || is_jump)
                          && (unit_i != unit_mul);

    assign forward_value_o = rd_value_next;
    assign forward_valid_o = single_cycle;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_write_en_o <= 1'b0;
        end else begin
            wb_write_en_o <= single_cycle & rd_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_addr_o  <= rd_addr_i;
        wb_rd_value_o <= rd_value_next;
    end

    // Destination travels two edges beside each multiply
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_wr_q1 <= 1'b0;
            mul_wr_q2 <= 1'b0;
        end else begin
            mul_wr_q1 <= mul_start & rd_write_i;
            mul_wr_q2 <= mul_wr_q1;
        end
    end

    always_ff @(posedge clk_i) begin
        mul_rd_q1     <= rd_addr_i;
        mul_rd_addr_o <= mul_rd_q1;
    end

    assign mul_write_en_o = mul_done & mul_wr_q2;

endmodule

// ==== verification/clock_reset_gen.sv ====
// Testbench clock and reset source with a 10 ns clock and a reset held for two edges, start or restart
`timescale 1ns/1ps

module clock_reset_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_o
);

    localparam int reset_cycles = 2;

    int unsigned edge_count;

    initial begin
        clk_o      = 1'b0;
        rst_o      = 1'b1;
        edge_count = 0;
    end

    always #5 clk_o = ~clk_o;                   // 10 ns period

    always @(posedge clk_o) begin
        if (restart_i) begin
            edge_count <= 0;                    // Restart request seen on this edge
            rst_o      <= 1'b1;
        end else if (edge_count < reset_cycles) begin
            edge_count <= edge_count + 1;
            rst_o      <= (edge_count + 1 < reset_cycles);
        end
    end

endmodule

// ==== verification/execute_model.svh ====
// Reference results for the execute stage; included by the testbench after the package import
`ifndef execute_model_svh
`define execute_model_svh

function automatic logic [31:0] ones_count(input logic [31:0] value);
    logic [31:0] total;
    total = '0;
    foreach (value[i]) begin
        total = total + value[i];
    end
    return total;
endfunction

function automatic logic [31:0] trailing_zero_count(input logic [31:0] value);
    int n;
    n = 0;
    while ((n < 32) && (value[n] == 1'b0)) begin
        n++;                                    // Stops at the lowest one bit
    end
    return 32'(n);
endfunction

function automatic logic [31:0] alu_value(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
        alu_sub:  return a - b;
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_sll:  return a << b[4:0];
        alu_srl:  return a >> b[4:0];
        alu_sra:  return 32'($signed(a) >>> b[4:0]);
        alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        default:  return a + b;
    endcase
endfunction

function automatic logic [31:0] bitmanip_value(input bit_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [31:0] reversed;
    for (int k = 0; k < 4; k++) begin
        reversed[8*k +: 8] = a[8*(3-k) +: 8];
    end
    case (op)
        bit_rvrs:  return reversed;
        bit_cntz:  return trailing_zero_count(a);
        bit_cntp:  return ones_count(a);
        bit_pkg:   return {b[15:0], a[15:0]};
        bit_sladd: return (a << 1) + b;
        bit_hmdst: return ones_count(a ^ b);
        default:   return '0;
    endcase
endfunction

// Products taken modulo 2^64 after extending each side to 64 bits
function automatic logic [31:0] product_word(input mul_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] wide_a;
    logic [63:0] wide_b;
    logic [63:0] prod;
    wide_a = (op == mul_mulh || op == mul_mulhsu) ? {{32{a[31]}}, a} : {32'd0, a};
    wide_b = (op == mul_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    prod   = wide_a * wide_b;
    return (op == mul_mul) ? prod[31:0] : prod[63:32];
endfunction

function automatic logic taken_rule(input branch_op_e op, input logic lt, input logic ltu,
                                    input logic eq);
    case (op)
        br_eq:           return eq;
        br_ne:           return !eq;
        br_lt:           return lt;
        br_ge:           return !lt;
        br_ltu:          return ltu;
        br_geu:          return !ltu;
        br_jal, br_jalr: return 1'b1;
        default:         return 1'b0;
    endcase
endfunction

`endif

// ==== verification/execute_stage_tb.sv ====
// Testbench for the execute stage; random micro-op groups checked by concurrent assertions
`timescale 1ns/1ps

module execute_stage_tb;

    import execute_pkg::*;

    `include "execute_model.svh"

    localparam int seed        = 9425;
    localparam int group_ops   = 200;
    localparam int cycle_limit = 2000;          // Five groups of 200 plus bubbles, resets, drain

    logic clk;
    logic rst;
    logic restart;
    unit_e unit;
    alu_op_e alu_op;
    bit_op_e bit_op;
    mul_op_e mul_op;
    branch_op_e branch_op;
    logic [4:0] rd_addr;
    logic rd_write;
    logic [31:1] pc_plus4;
    logic [31:0] value1;
    logic [31:0] value2;
    logic cmp_lt;
    logic cmp_ltu;
    logic cmp_eq;
    logic [31:1] branch_target;
    logic branch_taken;
    logic [31:0] forward_value;
    logic forward_valid;
    logic wb_write_en;
    logic [4:0] wb_rd_addr;
    logic [31:0] wb_rd_value;
    logic mul_write_en;
    logic [4:0] mul_rd_addr;
    logic [31:0] mul_value;

    logic exp_fwd_valid;                        // Issue cycle expectations
    logic [31:0] exp_fwd_value;
    logic exp_taken;
    logic exp_target_check;
    logic [31:1] exp_target;
    logic exp_wb_en;
    logic exp_mul_en;
    logic [31:0] exp_mul_value;
    logic wb_en_q;                              // One edge later
    logic [4:0] wb_addr_q;
    logic [31:0] wb_value_q;
    logic mul_en_q1;                            // Two edges later for multiplies
    logic mul_en_q2;
    logic [4:0] mul_addr_q1;
    logic [4:0] mul_addr_q2;
    logic [31:0] mul_value_q1;
    logic [31:0] mul_value_q2;

    int error_count;
    int issued;
    int mul_count;
    int cycle_count;
    int unsigned seed_state;

    clock_reset_gen clock_gen_i (.restart_i(restart), .clk_o(clk), .rst_o(rst));

    execute_stage execute_stage_i (
        .clk_i(clk), .rst_i(rst), .unit_i(unit), .alu_op_i(alu_op), .bit_op_i(bit_op),
        .mul_op_i(mul_op), .branch_op_i(branch_op), .rd_addr_i(rd_addr), .rd_write_i(rd_write),
        .pc_plus4_i(pc_plus4), .value1_i(value1), .value2_i(value2), .cmp_lt_i(cmp_lt),
        .cmp_ltu_i(cmp_ltu), .cmp_eq_i(cmp_eq), .branch_target_o(branch_target),
        .branch_taken_o(branch_taken), .forward_value_o(forward_value),
        .forward_valid_o(forward_valid), .wb_write_en_o(wb_write_en), .wb_rd_addr_o(wb_rd_addr),
        .wb_rd_value_o(wb_rd_value), .mul_write_en_o(mul_write_en),
        .mul_rd_addr_o(mul_rd_addr), .mul_value_o(mul_value)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic pick_write();
        return ($urandom_range(0, 7) != 0);     // Mostly writes a register
    endfunction

    task automatic issue(input unit_e u, input alu_op_e aop, input bit_op_e bop,
                         input mul_op_e mop, input branch_op_e bro, input logic [31:0] v1,
                         input logic [31:0] v2, input logic wr);
        logic [4:0] rd;
        logic [31:1] pc;
        logic lt;
        logic ltu;
        logic eq;
        logic jump;
        logic single;
        logic [31:0] sum;
        logic [31:0] result;
        rd     = 5'($urandom);
        pc     = 31'($urandom);
        lt     = 1'($urandom);
        ltu    = 1'($urandom);
        eq     = 1'($urandom);
        sum    = v1 + v2;
        jump   = (bro == br_jal) || (bro == br_jalr);
        single = (u == unit_alu) || (u == unit_bitmanip) || jump;
        if (jump) begin
            result = {pc, 1'b0};                // Link address
        end else if (u == unit_bitmanip) begin
            result = bitmanip_value(bop, v1, v2);
        end else begin
            result = alu_value(aop, v1, v2);
        end
        @(posedge clk);
        unit             <= u;
        alu_op           <= aop;
        bit_op           <= bop;
        mul_op           <= mop;
        branch_op        <= bro;
        rd_addr          <= rd;
        rd_write         <= wr;
        pc_plus4         <= pc;
        value1           <= v1;
        value2           <= v2;
        cmp_lt           <= lt;
        cmp_ltu          <= ltu;
        cmp_eq           <= eq;
        exp_fwd_valid    <= single;
        exp_fwd_value    <= result;
        exp_wb_en        <= single && wr;
        exp_taken        <= taken_rule(bro, lt, ltu, eq);
        exp_target       <= sum[31:1];
        exp_target_check <= (bro != br_none);
        exp_mul_en       <= (u == unit_mul) && wr;
        exp_mul_value    <= product_word(mop, v1, v2);
        issued++;
        if (u == unit_mul) begin
            mul_count++;
        end
    endtask

    task automatic issue_bubble();
        issue(unit_none, alu_op_e'($urandom_range(0, 9)), bit_op_e'($urandom_range(0, 5)),
              mul_op_e'($urandom_range(0, 3)), br_none, pick_operand(), pick_operand(),
              pick_write());
    endtask

    task automatic wait_reset_release();
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
    endtask

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en_q   <= 1'b0;
            mul_en_q1 <= 1'b0;
            mul_en_q2 <= 1'b0;
        end else begin
            wb_en_q   <= exp_wb_en;
            mul_en_q1 <= exp_mul_en;
            mul_en_q2 <= mul_en_q1;
        end
        wb_addr_q    <= rd_addr;                // Issued address, not the DUT output
        wb_value_q   <= exp_fwd_value;
        mul_addr_q1  <= rd_addr;
        mul_addr_q2  <= mul_addr_q1;
        mul_value_q1 <= exp_mul_value;
        mul_value_q2 <= mul_value_q1;
    end

    chk_reset_quiet: assert property (@(posedge clk) rst |=> (!wb_write_en && !mul_write_en))
        else begin
            error_count++;
            $display("[FAIL] %0t a write enable was high during or right after reset", $time);
        end

    chk_fwd_valid: assert property (@(posedge clk) disable iff (rst)
        forward_valid == exp_fwd_valid)
        else report_mismatch("forward_valid_o", $sampled(exp_fwd_valid), $sampled(forward_valid));
    chk_fwd_value: assert property (@(posedge clk) disable iff (rst)
        exp_fwd_valid |-> forward_value == exp_fwd_value)
        else report_mismatch("forward_value_o", $sampled(exp_fwd_value), $sampled(forward_value));
    chk_taken: assert property (@(posedge clk) disable iff (rst) branch_taken == exp_taken)
        else report_mismatch("branch_taken_o", $sampled(exp_taken), $sampled(branch_taken));
    chk_target: assert property (@(posedge clk) disable iff (rst)
        exp_target_check |-> branch_target == exp_target)
        else report_mismatch("branch_target_o", $sampled(exp_target), $sampled(branch_target));
    chk_wb_en: assert property (@(posedge clk) disable iff (rst) wb_write_en == wb_en_q)
        else report_mismatch("wb_write_en_o", $sampled(wb_en_q), $sampled(wb_write_en));
    chk_wb_addr: assert property (@(posedge clk) disable iff (rst)
        wb_en_q |-> wb_rd_addr == wb_addr_q)
        else report_mismatch("wb_rd_addr_o", $sampled(wb_addr_q), $sampled(wb_rd_addr));
    chk_wb_value: assert property (@(posedge clk) disable iff (rst)
        wb_en_q |-> wb_rd_value == wb_value_q)
        else report_mismatch("wb_rd_value_o", $sampled(wb_value_q), $sampled(wb_rd_value));
    chk_mul_en: assert property (@(posedge clk) disable iff (rst) mul_write_en == mul_en_q2)
        else report_mismatch("mul_write_en_o", $sampled(mul_en_q2), $sampled(mul_write_en));
    chk_mul_addr: assert property (@(posedge clk) disable iff (rst)
        mul_en_q2 |-> mul_rd_addr == mul_addr_q2)
        else report_mismatch("mul_rd_addr_o", $sampled(mul_addr_q2), $sampled(mul_rd_addr));
    chk_mul_value: assert property (@(posedge clk) disable iff (rst)
        mul_en_q2 |-> mul_value == mul_value_q2)
        else report_mismatch("mul_value_o", $sampled(mul_value_q2), $sampled(mul_value));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed_state = $urandom(seed);
        unit       = unit_none;
        alu_op     = alu_add;
        bit_op     = bit_rvrs;
        mul_op     = mul_mul;
        branch_op  = br_none;
        {rd_addr, rd_write, pc_plus4, value1, value2} = '0;
        {cmp_lt, cmp_ltu, cmp_eq, restart} = '0;
        {exp_fwd_valid, exp_fwd_value, exp_taken, exp_target_check, exp_target} = '0;
        {exp_wb_en, exp_mul_en, exp_mul_value} = '0;
        error_count = 0;
        issued      = 0;
        mul_count   = 0;
        cycle_count = 0;
        wait_reset_release();

        for (int n = 0; n < group_ops; n++) begin
            issue(unit_alu, alu_op_e'($urandom_range(0, 9)), bit_rvrs, mul_mul, br_none,
                  pick_operand(), pick_operand(), pick_write());
        end
        for (int n = 0; n < group_ops; n++) begin
            if (n % 25 == 0) begin
                issue(unit_bitmanip, alu_add, bit_cntz, mul_mul, br_none, '0, pick_operand(),
                      1'b1);                    // Zero input counts 32
            end else if (n % 25 == 1) begin
                issue(unit_bitmanip, alu_add, bit_hmdst, mul_mul, br_none, 32'h5a5a_c3c3,
                      32'h5a5a_c3c3, 1'b1);
            end else begin
                issue(unit_bitmanip, alu_add, bit_op_e'($urandom_range(0, 5)), mul_mul,
                      br_none, pick_operand(), pick_operand(), pick_write());
            end
        end
        for (int n = 0; n < group_ops; n++) begin
            issue(unit_mul, alu_add, bit_rvrs, mul_op_e'($urandom_range(0, 3)), br_none,
                  pick_operand(), pick_operand(), pick_write());
            if ($urandom_range(0, 2) == 0) begin
                issue_bubble();
            end
        end
        for (int n = 0; n < group_ops; n++) begin
            issue(unit_none, alu_add, bit_rvrs, mul_mul, branch_op_e'($urandom_range(1, 8)),
                  pick_operand(), pick_operand(), pick_write());
        end
        for (int n = 0; n < group_ops; n++) begin
            case ($urandom_range(0, 3))
                0: issue(unit_alu, alu_op_e'($urandom_range(0, 9)), bit_rvrs, mul_mul,
                         br_none, pick_operand(), pick_operand(), pick_write());
                1: issue(unit_bitmanip, alu_add, bit_op_e'($urandom_range(0, 5)), mul_mul,
                         br_none, pick_operand(), pick_operand(), pick_write());
                2: issue(unit_mul, alu_add, bit_rvrs, mul_op_e'($urandom_range(0, 3)),
                         br_none, pick_operand(), pick_operand(), pick_write());
                default: issue_bubble();
            endcase
        end

        // Multiply in the cycle before reset must never write back
        issue(unit_mul, alu_add, bit_rvrs, mul_mulhu, br_none, pick_operand(), pick_operand(),
              1'b1);
        restart <= 1'b1;
        issue_bubble();
        restart <= 1'b0;
        wait_reset_release();
        issue(unit_alu, alu_xor, bit_rvrs, mul_mul, br_none, pick_operand(), pick_operand(),
              1'b1);
        repeat (4) begin
            issue_bubble();
        end

        $display("Summary: %0d micro-ops issued, %0d multiplies, %0d errors",
                 issued, mul_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verification
source/execute_pkg.sv
source/arith_logic_unit.sv
source/bit_manip_unit.sv
source/multiplier_unit.sv
source/execute_stage.sv
verification/clock_reset_gen.sv
verification/execute_stage_tb.sv
